//--- hw/kbdPkg.sv
// PS/2 keyboard protocol definitions
package kbdPkg;

    // Raw PS/2 set 2 scan code
    typedef logic [7:0] scanCodeT;

    // ASCII code, zero when the key has no mapping
    typedef logic [7:0] asciiT;

    // Sent ahead of the scan code on key release
    localparam scanCodeT breakPrefix = 8'hF0;

    // Start, eight data, parity, stop
    localparam int frameBits = 11;

    // Scan code FIFO between receiver and tracker
    localparam int fifoDepth = 8;
    typedef logic [2:0] fifoPtrT;

    // Key tracker FSM
    typedef enum logic [1:0] {
        idle,      // No key held
        pressed,   // Make code seen, key held
        breakSeen  // F0 seen, release code follows
    } trackStateT;

endpackage

//--- hw/displayPkg.sv
// Seven-segment display definitions
package displayPkg;

    // Bit 0 is the top segment, bit 6 the middle one
    //    0
    //  5   1
    //    6
    //  4   2
    //    3
    typedef logic [6:0] segT;

    // Active-high patterns for hex digits 0 to F
    localparam segT hexDigitPattern [16] = '{
        7'b0111111, // 0
        7'b0000110, // 1
        7'b1011011, // 2
        7'b1001111, // 3
        7'b1100110, // 4
        7'b1101101, // 5
        7'b1111101, // 6
        7'b0000111, // 7
        7'b1111111, // 8
        7'b1101111, // 9
        7'b1110111, // A
        7'b1111100, // b
        7'b0111001, // C
        7'b1011110, // d
        7'b1111001, // E
        7'b1110001  // F
    };

    localparam segT segOff = 7'b1111111; // Active low, all dark

    typedef logic [7:0] pressCountT; // Wraps at 255

    localparam int digitCount = 6;

endpackage

//--- hw/keyStatusIf.sv
// Tracked key state bundle
`timescale 1ns/1ps

interface keyStatusIf;

    kbdPkg::scanCodeT       keyCode;    // Scan code of the held key
    kbdPkg::asciiT          asciiCode;  // Its ASCII code
    logic                   pressed;    // A key is held
    displayPkg::pressCountT pressCount; // Presses since reset

    modport tracker (
        output keyCode,
        output asciiCode,
        output pressed,
        output pressCount
    );

    modport display (
        input keyCode,
        input asciiCode,
        input pressed,
        input pressCount
    );

endinterface

//--- hw/asciiLookup.sv
// Scan code to ASCII table
`timescale 1ns/1ps

module asciiLookup (
    input  kbdPkg::scanCodeT scanCode,
    output kbdPkg::asciiT    ascii
);

    always_comb begin
        case (scanCode)
            8'h0E:   ascii = 8'h7E; // ~
            8'h16:   ascii = 8'h31; // 1
            8'h1E:   ascii = 8'h32; // 2
            8'h26:   ascii = 8'h33; // 3
            8'h25:   ascii = 8'h34; // 4
            8'h2E:   ascii = 8'h35; // 5
            8'h36:   ascii = 8'h36; // 6
            8'h3D:   ascii = 8'h37; // 7
            8'h3E:   ascii = 8'h38; // 8
            8'h46:   ascii = 8'h39; // 9
            8'h45:   ascii = 8'h30; // 0
            8'h4E:   ascii = 8'h2D; // Minus
            8'h55:   ascii = 8'h3D; // Equals
            8'h5D:   ascii = 8'h5C; // Backslash
            8'h54:   ascii = 8'h5B; // Left bracket
            8'h5B:   ascii = 8'h5D; // Right bracket
            8'h4C:   ascii = 8'h3B; // Semicolon
            8'h52:   ascii = 8'h27; // Apostrophe
            8'h41:   ascii = 8'h2C; // Comma
            8'h49:   ascii = 8'h2E; // Period
            8'h4A:   ascii = 8'h2F; // Slash

            // Letters, lowercase only
            8'h1C:   ascii = 8'h61; // a
            8'h32:   ascii = 8'h62; // b
            8'h21:   ascii = 8'h63; // c
            8'h23:   ascii = 8'h64; // d
            8'h24:   ascii = 8'h65; // e
            8'h2B:   ascii = 8'h66; // f
            8'h34:   ascii = 8'h67; // g
            8'h33:   ascii = 8'h68; // h
            8'h43:   ascii = 8'h69; // i
            8'h3B:   ascii = 8'h6A; // j
            8'h42:   ascii = 8'h6B; // k
            8'h4B:   ascii = 8'h6C; // l
            8'h3A:   ascii = 8'h6D; // m
            8'h31:   ascii = 8'h6E; // n
            8'h44:   ascii = 8'h6F; // o
            8'h4D:   ascii = 8'h70; // p
            8'h15:   ascii = 8'h71; // q
            8'h2D:   ascii = 8'h72; // r
            8'h1B:   ascii = 8'h73; // s
            8'h2C:   ascii = 8'h74; // t
            8'h3C:   ascii = 8'h75; // u
            8'h2A:   ascii = 8'h76; // v
            8'h1D:   ascii = 8'h77; // w
            8'h22:   ascii = 8'h78; // x
            8'h35:   ascii = 8'h79; // y
            8'h1A:   ascii = 8'h7A; // z

            default: ascii = 8'h00; // Unmapped key
        endcase
    end

endmodule

//--- hw/ps2FrameReceiver.sv
// PS/2 frame receiver
`timescale 1ns/1ps

module ps2FrameReceiver (
    input  logic             clk,
    input  logic             rstN,
    input  logic             ps2Clk,
    input  logic             ps2Data,
    output kbdPkg::scanCodeT code,
    output logic             codeValid
);

    logic [2:0]                   clkSync;  // PS/2 clock synchronizer
    logic [3:0]                   bitCount; // Bits taken in this frame
    logic [kbdPkg::frameBits-2:0] frameBuf; // Start, data, parity
    logic                         fallSeen;
    logic                         lastBit;
    logic                         frameOk;

    assign fallSeen = clkSync[2] & ~clkSync[1];
    assign lastBit  = bitCount == 4'(kbdPkg::frameBits - 1);

    // Stop bit is still on the line at the last fall
    assign frameOk = ~frameBuf[0] &    // Start bit low
                     ps2Data &         // Stop bit high
                     ^frameBuf[9:1];   // Odd parity over data and parity bit

    // Data bits sit untouched until the next frame starts
    assign code = frameBuf[8:1];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            clkSync   <= '1; // Idle line is high
            bitCount  <= '0;
            codeValid <= 1'b0;
        end else begin
            clkSync   <= {clkSync[1:0], ps2Clk};
            codeValid <= 1'b0;
            if (fallSeen) begin
                if (lastBit) begin
                    codeValid <= frameOk; // Bad frames are dropped silently
                    bitCount  <= '0;
                end else begin
                    bitCount <= bitCount + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fallSeen && !lastBit) begin
            frameBuf[bitCount] <= ps2Data;
        end
    end

    // Count always restarts on the eleventh bit
    bitCountInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        bitCount < 4'(kbdPkg::frameBits)
    ) else $error("PS/2 bit counter out of range: %0d", bitCount);

endmodule

//--- hw/scanCodeFifo.sv
// Scan code FIFO
`timescale 1ns/1ps

module scanCodeFifo (
    input  logic             clk,
    input  logic             rstN,
    input  kbdPkg::scanCodeT pushCode,
    input  logic             push,
    input  logic             pop,
    output kbdPkg::scanCodeT headCode,
    output logic             notEmpty
);

    kbdPkg::scanCodeT mem [kbdPkg::fifoDepth];
    kbdPkg::fifoPtrT  wrPtr;
    kbdPkg::fifoPtrT  rdPtr;
    logic [3:0]       fillCount; // 0 to fifoDepth
    logic             full;
    logic             doPush;
    logic             doPop;

    assign full     = fillCount == 4'(kbdPkg::fifoDepth);
    assign notEmpty = fillCount != '0;
    assign doPush   = push && !full; // Code lost when full
    assign doPop    = pop && notEmpty;
    assign headCode = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushCode;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            fillCount <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + kbdPkg::fifoPtrT'(1); // Wraps with the pointer width
            end
            if (doPop) begin
                rdPtr <= rdPtr + kbdPkg::fifoPtrT'(1);
            end
            case ({doPush, doPop})
                2'b10:   fillCount <= fillCount + 4'd1;
                2'b01:   fillCount <= fillCount - 4'd1;
                default: fillCount <= fillCount;
            endcase
        end
    end

    // The tracker must only pop what is there
    noPopWhenEmpty: assert property (
        @(posedge clk) disable iff (!rstN)
        pop |-> notEmpty
    ) else $error("Scan code FIFO popped while empty");

endmodule

//--- hw/keyTracker.sv
// Key press tracker
`timescale 1ns/1ps

module keyTracker (
    input  logic             clk,
    input  logic             rstN,
    input  kbdPkg::scanCodeT headCode,
    input  logic             notEmpty,
    output logic             pop,
    keyStatusIf.tracker      status
);

    kbdPkg::trackStateT state;
    kbdPkg::asciiT      lookupAscii;
    logic               newPress;

    asciiLookup iLookup (
        .scanCode (headCode),
        .ascii    (lookupAscii)
    );

    // Drain one code per cycle
    assign pop = notEmpty;

    // Typematic repeats of the held key are not a new press
    assign newPress = pop && (headCode != kbdPkg::breakPrefix) &&
                      ((state == kbdPkg::idle) ||
                       (state == kbdPkg::pressed && headCode != status.keyCode));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state             <= kbdPkg::idle;
            status.pressed    <= 1'b0;
            status.pressCount <= '0;
        end else if (pop) begin
            if (state == kbdPkg::breakSeen) begin
                state          <= kbdPkg::idle; // Released key code
                status.pressed <= 1'b0;
            end else if (headCode == kbdPkg::breakPrefix) begin
                state <= kbdPkg::breakSeen;
            end else if (newPress) begin
                state             <= kbdPkg::pressed;
                status.pressed    <= 1'b1;
                status.pressCount <= status.pressCount + displayPkg::pressCountT'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (newPress) begin
            status.keyCode   <= headCode;
            status.asciiCode <= lookupAscii;
        end
    end

    // Count moves only forward, one press at a time
    countStepsByOne: assert property (
        @(posedge clk) disable iff (!rstN)
        $past(rstN) && $changed(status.pressCount) |->
            status.pressCount == displayPkg::pressCountT'($past(status.pressCount) + 1)
    ) else $error("Press count jumped to %0h", status.pressCount);

endmodule

//--- hw/segmentDisplay.sv
// Six-digit key status display
`timescale 1ns/1ps

module segmentDisplay (
    keyStatusIf.display     status,
    output displayPkg::segT seg0,
    output displayPkg::segT seg1,
    output displayPkg::segT seg2,
    output displayPkg::segT seg3,
    output displayPkg::segT seg4,
    output displayPkg::segT seg5
);

    logic [4*displayPkg::digitCount-1:0] nibbles;
    displayPkg::segT                     digits [displayPkg::digitCount];

    // Active-low pattern for one hex nibble
    function automatic displayPkg::segT hexSeg(input logic [3:0] nibble);
        return ~displayPkg::hexDigitPattern[nibble];
    endfunction

    // Count on top, then ASCII, then scan code
    assign nibbles = {status.pressCount, status.asciiCode, status.keyCode};

    always_comb begin
        for (int i = 0; i < displayPkg::digitCount; i++) begin
            if (i < 4 && !status.pressed) begin
                digits[i] = displayPkg::segOff; // Key digits dark when released
            end else begin
                digits[i] = hexSeg(nibbles[4*i +: 4]);
            end
        end
    end

    assign seg0 = digits[0]; // Scan code low
    assign seg1 = digits[1];
    assign seg2 = digits[2]; // ASCII low
    assign seg3 = digits[3];
    assign seg4 = digits[4]; // Count low
    assign seg5 = digits[5];

endmodule

//--- hw/kbdDisplayTop.sv
// PS/2 keyboard display top level
`timescale 1ns/1ps

module kbdDisplayTop (
    input  logic            clk,
    input  logic            rstN,
    input  logic            ps2Clk,
    input  logic            ps2Data,
    output displayPkg::segT seg0,
    output displayPkg::segT seg1,
    output displayPkg::segT seg2,
    output displayPkg::segT seg3,
    output displayPkg::segT seg4,
    output displayPkg::segT seg5
);

    kbdPkg::scanCodeT rxCode;
    logic             rxValid;
    kbdPkg::scanCodeT headCode;
    logic             notEmpty;
    logic             pop;

    keyStatusIf keyStatus ();

    ps2FrameReceiver iReceiver (
        .clk       (clk),
        .rstN      (rstN),
        .ps2Clk    (ps2Clk),
        .ps2Data   (ps2Data),
        .code      (rxCode),
        .codeValid (rxValid)
    );

    scanCodeFifo iFifo (
        .clk      (clk),
        .rstN     (rstN),
        .pushCode (rxCode),
        .push     (rxValid),
        .pop      (pop),
        .headCode (headCode),
        .notEmpty (notEmpty)
    );

    keyTracker iTracker (
        .clk      (clk),
        .rstN     (rstN),
        .headCode (headCode),
        .notEmpty (notEmpty),
        .pop      (pop),
        .status   (keyStatus.tracker)
    );

    segmentDisplay iDisplay (
        .status (keyStatus.display),
        .seg0   (seg0),
        .seg1   (seg1),
        .seg2   (seg2),
        .seg3   (seg3),
        .seg4   (seg4),
        .seg5   (seg5)
    );

endmodule

//--- include/ps2TbTasks.svh
// PS/2 testbench tasks
`ifndef PS2_TB_TASKS_SVH
`define PS2_TB_TASKS_SVH

// Sends one frame, LSB first, device drives data while the clock is high
task automatic sendFrame(input kbdPkg::scanCodeT code, input bit badParity);
    logic [10:0] frame;
    logic        parityBit;
    parityBit = ~^code ^ badParity; // Odd parity unless forced bad
    frame = {1'b1, parityBit, code, 1'b0};
    for (int i = 0; i < kbdPkg::frameBits; i++) begin
        @(posedge clk);
        ps2Data <= frame[i];
        repeat (ps2HalfCycles) @(posedge clk);
        ps2Clk <= 1'b0;
        repeat (ps2HalfCycles) @(posedge clk);
        ps2Clk <= 1'b1;
    end
    repeat (ps2HalfCycles) @(posedge clk); // Idle gap after the stop bit
endtask

// Back from an active-low pattern to its hex digit
function automatic logic [3:0] segToNibble(input displayPkg::segT pattern);
    for (int n = 0; n < 16; n++) begin
        if (~displayPkg::hexDigitPattern[n] == pattern) begin
            return 4'(n);
        end
    end
    return 4'hx; // Not a digit
endfunction

task automatic checkSeg(input string name, input displayPkg::segT actual,
                        input displayPkg::segT expected);
    if (actual !== expected) begin
        $display("FAILED %s: got %h, expected %h", name, actual, expected);
        checkErrors++;
    end
endtask

task automatic checkCount(input displayPkg::pressCountT actual,
                          input displayPkg::pressCountT expected);
    if (actual !== expected) begin
        $display("FAILED pressCount: got %h, expected %h", actual, expected);
        checkErrors++;
    end
endtask

`endif

//--- testbench/kbdDisplayTb.sv
// Keyboard display testbench
`timescale 1ns/1ps

module kbdDisplayTb;

    localparam int ps2HalfCycles  = 20;
    localparam int displayTimeout = 200; // Cycles to wait for the display
    localparam int randomPresses  = 8;
    localparam int keyCount       = 12;

    // Subset of the key map, also the pool for random presses
    localparam kbdPkg::scanCodeT keyScan [keyCount] = '{
        8'h1C, 8'h32, 8'h21, 8'h1A, 8'h15, 8'h3A,
        8'h45, 8'h16, 8'h46, 8'h0E, 8'h4E, 8'h4A
    };
    localparam kbdPkg::asciiT keyAscii [keyCount] = '{
        8'h61, 8'h62, 8'h63, 8'h7A, 8'h71, 8'h6D, // a b c z q m
        8'h30, 8'h31, 8'h39, 8'h7E, 8'h2D, 8'h2F  // 0 1 9 ~ - /
    };

    typedef struct {
        string                  name;
        logic [23:0]            codes;     // Sent from the top byte down
        int                     numCodes;
        bit                     badParity;
        kbdPkg::scanCodeT       expCode;
        kbdPkg::asciiT          expAscii;
        bit                     expPressed;
        displayPkg::pressCountT expCount;
    } stepT;

    logic            clk;
    logic            rstN;
    logic            ps2Clk;
    logic            ps2Data;
    displayPkg::segT seg [displayPkg::digitCount];
    displayPkg::segT expSeg [displayPkg::digitCount];
    stepT            steps [$];
    int              checkErrors;
    int              passCount;
    int              failCount;
    integer          seed;

    `include "ps2TbTasks.svh"

    kbdDisplayTop i_dut (
        .clk     (clk),
        .rstN    (rstN),
        .ps2Clk  (ps2Clk),
        .ps2Data (ps2Data),
        .seg0    (seg[0]),
        .seg1    (seg[1]),
        .seg2    (seg[2]),
        .seg3    (seg[3]),
        .seg4    (seg[4]),
        .seg5    (seg[5])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic kbdPkg::asciiT asciiOf(input kbdPkg::scanCodeT code);
        for (int k = 0; k < keyCount; k++) begin
            if (keyScan[k] == code) begin
                return keyAscii[k];
            end
        end
        return 8'h00;
    endfunction

    // Count on 5:4, ASCII on 3:2, scan code on 1:0, key digits dark when released
    function automatic displayPkg::segT expectDigit(input int idx, input stepT s);
        logic [23:0] nib;
        nib = {s.expCount, s.expAscii, s.expCode};
        if (idx < 4 && !s.expPressed) begin
            return displayPkg::segOff;
        end
        return ~displayPkg::hexDigitPattern[nib[4*idx +: 4]];
    endfunction

    task automatic addStep(input string name, input logic [23:0] codes, input int numCodes,
                           input bit badParity, input kbdPkg::scanCodeT expCode,
                           input kbdPkg::asciiT expAscii, input bit expPressed,
                           input displayPkg::pressCountT expCount);
        stepT s;
        s = '{name, codes, numCodes, badParity, expCode, expAscii, expPressed, expCount};
        steps.push_back(s);
    endtask

    task automatic waitForDisplay(output bit settled);
        settled = 1'b0;
        for (int c = 0; c < displayTimeout && !settled; c++) begin
            @(negedge clk); // Outputs are stable mid-cycle
            settled = 1'b1;
            for (int d = 0; d < displayPkg::digitCount; d++) begin
                if (seg[d] !== expSeg[d]) settled = 1'b0;
            end
        end
    endtask

    initial begin
        displayPkg::pressCountT count;
        int                     idx;
        int                     errsBefore;
        bit                     settled;

        rstN        = 1'b0;
        ps2Clk      = 1'b1; // Idle bus
        ps2Data     = 1'b1;
        checkErrors = 0;
        passCount   = 0;
        failCount   = 0;
        seed        = 47216;

        addStep("after reset", 24'h000000, 0, 1'b0, 8'h00, 8'h00, 1'b0, 8'd0);
        addStep("press a", 24'h1C0000, 1, 1'b0, 8'h1C, 8'h61, 1'b1, 8'd1);
        addStep("typematic a", 24'h1C1C1C, 3, 1'b0, 8'h1C, 8'h61, 1'b1, 8'd1);
        addStep("release a", 24'hF01C00, 2, 1'b0, 8'h1C, 8'h61, 1'b0, 8'd1);
        addStep("press 5", 24'h2E0000, 1, 1'b0, 8'h2E, 8'h35, 1'b1, 8'd2);
        addStep("bad parity", 24'h1C0000, 1, 1'b1, 8'h2E, 8'h35, 1'b1, 8'd2);
        addStep("release 5", 24'hF02E00, 2, 1'b0, 8'h2E, 8'h35, 1'b0, 8'd2);
        addStep("unmapped key", 24'h050000, 1, 1'b0, 8'h05, 8'h00, 1'b1, 8'd3);
        addStep("release unmapped", 24'hF00500, 2, 1'b0, 8'h05, 8'h00, 1'b0, 8'd3);

        count = 8'd3;
        for (int k = 0; k < randomPresses; k++) begin
            idx   = $unsigned($random(seed)) % keyCount;
            count = count + 8'd1; // Wraps like the display count
            addStep($sformatf("random press %0d", k), {keyScan[idx], 16'h0000}, 1, 1'b0,
                    keyScan[idx], asciiOf(keyScan[idx]), 1'b1, count);
            addStep($sformatf("random release %0d", k), {8'hF0, keyScan[idx], 8'h00}, 2,
                    1'b0, keyScan[idx], asciiOf(keyScan[idx]), 1'b0, count);
        end

        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        foreach (steps[i]) begin
            errsBefore = checkErrors;
            for (int k = 0; k < steps[i].numCodes; k++) begin
                sendFrame(steps[i].codes[23-8*k -: 8], steps[i].badParity);
            end
            for (int d = 0; d < displayPkg::digitCount; d++) begin
                expSeg[d] = expectDigit(d, steps[i]);
            end
            waitForDisplay(settled);
            if (!settled) begin
                $display("Step %0d %s: display did not reach the expected value in %0d cycles",
                         i, steps[i].name, displayTimeout);
                checkErrors++;
            end
            for (int d = 0; d < 4; d++) begin
                checkSeg($sformatf("seg%0d", d), seg[d], expSeg[d]);
            end
            checkCount({segToNibble(seg[5]), segToNibble(seg[4])}, steps[i].expCount);
            if (checkErrors == errsBefore) begin
                passCount++;
                $display("Step %0d %s: passed", i, steps[i].name);
            end else begin
                failCount++;
                $display("Step %0d %s: failed", i, steps[i].name);
            end
        end

        $display("Tests: %0d passed, %0d failed, %0d check errors",
                 passCount, failCount, checkErrors);
        if (checkErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- kbdDisplayTop.f
+incdir+include
hw/kbdPkg.sv
hw/displayPkg.sv
hw/keyStatusIf.sv
hw/asciiLookup.sv
hw/ps2FrameReceiver.sv
hw/scanCodeFifo.sv
hw/keyTracker.sv
hw/segmentDisplay.sv
hw/kbdDisplayTop.sv
testbench/kbdDisplayTb.sv
